// ==== dv/spi_tx_checker.sv ====
// SPI pin monitor and scoreboard
`timescale 1ns/1ps

module spi_tx_checker import spi_tx_pkg::*; #(
    parameter int NUM_TESTS  = 20,
    parameter int FIFO_DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic req_valid,
    input  logic req_ready,
    input  logic sdo,
    input  logic sclk,
    input  logic cs_n,
    input  logic busy,
    input  logic frame_done,
    output int   err_count,
    output int   byte_count,
    output int   done_count
);

    logic [19:0]        tests [NUM_TESTS];
    logic [FRAME_W-1:0] shreg;
    int                 bit_cnt;
    int                 txn;                // Transactions closed so far
    int                 held;               // Queue entries implied by the pins
    logic               push_next;          // Host handshake due on the next rising edge
    logic               popped;
    logic               in_byte;            // Frame popped and still shifting
    logic               sclk_prev;
    logic               cs_prev;
    logic               done_prev;

    initial begin
        $readmemh("dv/spi_tx_tests.txt", tests);
        err_count  = 0;
        byte_count = 0;
        done_count = 0;
    end

    // Compare a rebuilt byte with the next expected entry
    task automatic check_byte(input logic [FRAME_W-1:0] b);
        if (byte_count >= NUM_TESTS) begin
            $display("Extra byte %h seen after all expected frames", b);
            err_count++;
        end else begin
            if (b !== tests[byte_count][7:0]) begin
                $display("FAILED %0t: byte %0d data %h expected %h",
                         $time, byte_count, b, tests[byte_count][7:0]);
                err_count++;
            end
            if (txn !== int'(tests[byte_count][19:12])) begin
                $display("FAILED %0t: byte %0d in transaction %0d expected %0d",
                         $time, byte_count, txn, tests[byte_count][19:12]);
                err_count++;
            end
        end
        byte_count++;
    endtask

    // Pins sampled on the falling clock edge
    always @(negedge clk) begin
        if (!rst_n) begin
            bit_cnt   = 0;
            txn       = 0;
            held      = 0;
            push_next = 1'b0;
            popped    = 1'b0;
            in_byte   = 1'b0;
            shreg     = '0;
            sclk_prev = 1'b1;
            cs_prev   = 1'b1;
            done_prev = 1'b0;
        end else begin
            if (busy !== ~cs_n) begin
                $display("FAILED %0t: busy %b with cs_n %b", $time, busy, cs_n);
                err_count++;
            end
            if (frame_done && !done_prev) begin
                done_count++;
                if (done_count > NUM_TESTS) begin
                    $display("More frame_done pulses than expected frames");
                    err_count++;
                end
            end
            // A frame leaves the queue when cs_n falls, or inside a
            // transaction at the first sclk fall of a byte
            popped = !cs_n && (cs_prev || (!sclk && sclk_prev && !in_byte));
            if (popped) begin
                in_byte = 1'b1;
            end
            held = held + int'(push_next) - int'(popped);
            if (req_ready !== (held < FIFO_DEPTH)) begin
                $display("FAILED %0t: req_ready %b with %0d requests queued",
                         $time, req_ready, held);
                err_count++;
            end
            push_next = req_valid && req_ready;
            if (!cs_n && sclk && !sclk_prev) begin    // Rising sclk, data sampled
                shreg = {shreg[FRAME_W-2:0], sdo};
                bit_cnt++;
                if (bit_cnt == FRAME_W) begin
                    check_byte(shreg);
                    bit_cnt = 0;
                    in_byte = 1'b0;
                end
            end
            if (cs_n && !cs_prev) begin
                if (bit_cnt != 0) begin
                    $display("Chip select released in the middle of a byte");
                    err_count++;
                    bit_cnt = 0;
                end
                in_byte = 1'b0;
                txn++;
            end
            sclk_prev = sclk;
            cs_prev   = cs_n;
            done_prev = frame_done;
        end
    end

endmodule

// ==== dv/spi_tx_sva.sv ====
// SPI master timing assertions
`timescale 1ns/1ps

module spi_tx_sva import spi_tx_pkg::*; #(
    parameter int CLK_DIV = 4
) (
    input logic     clk,
    input logic     rst_n,
    input logic     frm_valid,
    input logic     frm_ready,
    input spi_req_t frm,
    input logic     sdo,
    input logic     sclk,
    input logic     cs_n,
    input logic     frame_done
);

    localparam int HALF = CLK_DIV / 2;

    // Idle levels on the first cycle out of reset
    a_reset_pins: assert property (@(posedge clk)
        $rose(rst_n) |-> cs_n && sclk && !frame_done && frm_ready)
        else $error("Pins not at idle levels after reset");

    a_sclk_low: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(sclk) |-> (!sclk)[*HALF] ##1 sclk)
        else $error("sclk low phase length wrong");

    a_sclk_high: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sclk) |-> sclk[*HALF])
        else $error("sclk high phase too short");

    // Lead delay from chip select to first falling sclk
    a_lead: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cs_n) |-> sclk[*CLK_DIV] ##1 $fell(sclk))
        else $error("Lead delay wrong");

    a_sdo_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (!cs_n && $past(!cs_n) && sclk && $past(sclk)) |-> $stable(sdo))
        else $error("sdo changed while sclk high");

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(frame_done) |=> !frame_done)
        else $error("frame_done longer than one cycle");

    a_frm_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (frm_valid && !frm_ready) |=> $stable(frm))
        else $error("Frame request changed while stalled");

endmodule

bind spi_shift_master spi_tx_sva #(.CLK_DIV(CLK_DIV)) u_sva (.*);

// ==== dv/spi_tx_tb.sv ====
// SPI transmit testbench
`timescale 1ns/1ps

module spi_tx_tb import spi_tx_pkg::*;;

    localparam int CLK_DIV    = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int NUM_TESTS  = 20;
    localparam int MAX_GAP    = 7;
    localparam int LIMIT      = NUM_TESTS * (FRAME_W * CLK_DIV + 2 * CLK_DIV + 10)
                              + NUM_TESTS * MAX_GAP + 20;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    spi_req_t    req;
    logic        req_ready;
    logic        sdo;
    logic        sclk;
    logic        cs_n;
    logic        busy;
    logic        frame_done;
    int          err_count;
    int          byte_count;
    int          done_count;
    int          count_errs;
    logic [19:0] tests [NUM_TESTS];
    logic [31:0] lfsr;

    spi_tx_top #(
        .CLK_DIV    (CLK_DIV),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_spi_tx_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .sdo        (sdo),
        .sclk       (sclk),
        .cs_n       (cs_n),
        .busy       (busy),
        .frame_done (frame_done)
    );

    spi_tx_checker #(
        .NUM_TESTS  (NUM_TESTS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .sdo        (sdo),
        .sclk       (sclk),
        .cs_n       (cs_n),
        .busy       (busy),
        .frame_done (frame_done),
        .err_count  (err_count),
        .byte_count (byte_count),
        .done_count (done_count)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int next_gap();
        int g;
        g = 0;
        repeat (3) begin
            lfsr = lfsr_step(lfsr);
            g    = (g << 1) | int'(lfsr[0]);
        end
        return g;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Timed out before all frames were seen (%0d of %0d)", done_count, NUM_TESTS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int gap;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        lfsr       = 32'hbcfa_44d3;
        count_errs = 0;
        $readmemh("dv/spi_tx_tests.txt", tests);
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < NUM_TESTS; i++) begin
            gap = next_gap();
            if (i >= 4 && i <= 11) begin
                gap = 0;                    // Burst to fill the queue
            end
            if (gap > 0) begin
                req_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            req_valid <= 1'b1;
            req.op    <= spi_op_e'(tests[i][8]);
            req.data  <= tests[i][7:0];
            @(negedge clk);
            while (!req_ready) @(negedge clk);   // Request held while stalled
            @(posedge clk);
        end
        req_valid <= 1'b0;
        wait (done_count == NUM_TESTS);
        repeat (4 * CLK_DIV) @(posedge clk);
        if (byte_count != NUM_TESTS) begin
            $display("FAILED %0t: %0d bytes seen, expected %0d", $time, byte_count, NUM_TESTS);
            count_errs++;
        end
        if (done_count != NUM_TESTS) begin
            $display("FAILED %0t: %0d frame_done pulses, expected %0d",
                     $time, done_count, NUM_TESTS);
            count_errs++;
        end
        $display("Errors: checker %0d, count %0d", err_count, count_errs);
        if (err_count == 0 && count_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== dv/spi_tx_tests.txt ====
// Columns: TT_O_DD, TT expected transaction index, O opcode (0 write, 1 write_cont),
// DD data byte. All hex.
00_0_a5
01_1_3c
01_1_81
01_0_7e
02_0_01
03_0_ff
04_1_55
04_1_aa
04_0_96
05_0_00
06_0_c3
07_1_12
07_1_34
07_0_56
08_0_80
09_1_01
09_0_fe
0a_0_69
0b_1_e7
0b_0_18

// ==== hdl/spi_req_fifo.sv ====
// Frame request queue
`timescale 1ns/1ps

module spi_req_fifo import spi_tx_pkg::*; #(
    parameter int FIFO_DEPTH = 4            // Number of requests held
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  spi_req_t in_req,
    output logic     in_ready,
    output logic     out_valid,
    output spi_req_t out_req,
    input  logic     out_ready
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

    spi_req_t         mem [FIFO_DEPTH];     // Entry storage
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;              // Entries currently held
    logic             push;
    logic             pop;

    // Pointer advance with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_LAST) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Full blocks the input even when a pop happens in the same cycle
    assign in_ready  = (count_q != CNT_FULL);
    assign out_valid = (count_q != '0);
    assign out_req   = mem[rd_ptr_q];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    // Storage write
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= in_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
        end
    end

    // Occupancy, unchanged when push and pop coincide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else begin
            case ({push, pop})
                2'b10: begin
                    count_q <= count_q + 1'b1;
                end
                2'b01: begin
                    count_q <= count_q - 1'b1;
                end
                default: begin
                    count_q <= count_q;
                end
            endcase
        end
    end

endmodule

// ==== hdl/spi_shift_master.sv ====
// SPI mode 3 transmit engine
`timescale 1ns/1ps

module spi_shift_master import spi_tx_pkg::*; #(
    parameter int CLK_DIV = 4               // System clocks per sclk period, even, >= 2
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     frm_valid,
    input  spi_req_t frm,
    output logic     frm_ready,
    output logic     sdo,
    output logic     sclk,
    output logic     cs_n,
    output logic     busy,
    output logic     frame_done
);

    localparam int DIV_W = $clog2(CLK_DIV);
    localparam int BIT_W = $clog2(FRAME_W);
    localparam logic [DIV_W-1:0] HALF_LAST = DIV_W'(CLK_DIV / 2 - 1);
    localparam logic [DIV_W-1:0] DLY_LAST  = DIV_W'(CLK_DIV - 1);
    localparam logic [BIT_W-1:0] BIT_LAST  = BIT_W'(FRAME_W - 1);

    typedef enum logic [2:0] {
        IDLE  = 3'd0,   // cs_n high, waiting for a frame
        LEAD  = 3'd1,   // cs_n low before the first sclk edge
        SHIFT = 3'd2,
        TRAIL = 3'd3,   // cs_n low after the last rising edge
        HOLD  = 3'd4,   // Transaction kept open
        DONE  = 3'd5
    } state_e;

    state_e             state_q;
    state_e             state_d;
    logic [DIV_W-1:0]   half_cnt_q;         // Cycles into the current sclk phase
    logic [DIV_W-1:0]   dly_cnt_q;          // Shared by LEAD and TRAIL
    logic [BIT_W-1:0]   bit_cnt_q;
    logic [FRAME_W-1:0] shift_q;
    spi_op_e            op_q;               // Opcode of the frame in flight
    logic               sclk_q;
    logic               cs_n_q;
    logic               done_q;

    logic accept;
    logic half_end;
    logic bit_end;
    logic last_bit;
    logic dly_end;

    // Ready only where a new byte can start
    assign frm_ready = (state_q == IDLE) || (state_q == HOLD);
    assign accept    = frm_valid && frm_ready;

    assign half_end = (state_q == SHIFT) && (half_cnt_q == HALF_LAST);
    assign bit_end  = half_end && sclk_q;   // End of high phase closes a bit
    assign last_bit = bit_end && (bit_cnt_q == BIT_LAST);
    assign dly_end  = (dly_cnt_q == DLY_LAST);

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = LEAD;
                end
            end
            LEAD: begin
                if (dly_end) begin
                    state_d = SHIFT;
                end
            end
            SHIFT: begin
                if (last_bit) begin
                    state_d = (op_q == OP_WRITE_CONT) ? HOLD : TRAIL;
                end
            end
            TRAIL: begin
                if (dly_end) begin
                    state_d = DONE;
                end
            end
            HOLD: begin
                if (accept) begin
                    state_d = SHIFT;    // No lead delay inside a transaction
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // State and registered pin controls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cs_n_q  <= 1'b1;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            cs_n_q  <= (state_d == IDLE) || (state_d == DONE);
            // High for the DONE cycle or the first HOLD cycle
            done_q  <= (state_d == DONE) || ((state_q == SHIFT) && (state_d == HOLD));
        end
    end

    // LEAD and TRAIL both last CLK_DIV cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dly_cnt_q <= '0;
        end else if ((state_q == LEAD || state_q == TRAIL) && !dly_end) begin
            dly_cnt_q <= dly_cnt_q + 1'b1;
        end else begin
            dly_cnt_q <= '0;
        end
    end

    // sclk divider, phase toggles every CLK_DIV/2 cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_q     <= 1'b1;
            half_cnt_q <= '0;
        end else if ((state_d == SHIFT) && (state_q != SHIFT)) begin
            sclk_q     <= 1'b0;     // First falling edge of the byte
            half_cnt_q <= '0;
        end else if (half_end) begin
            half_cnt_q <= '0;
            if (!last_bit) begin
                sclk_q <= ~sclk_q;
            end
        end else if (state_q == SHIFT) begin
            half_cnt_q <= half_cnt_q + 1'b1;
        end
    end

    // Bits sent so far in this byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt_q <= '0;
        end else if (state_q != SHIFT) begin
            bit_cnt_q <= '0;
        end else if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
        end
    end

    // Byte load on accept; later bits move up on falling sclk
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_q <= '0;
            op_q    <= OP_WRITE;
        end else if (accept) begin
            shift_q <= frm.data;
            op_q    <= frm.op;
        end else if (bit_end && !last_bit) begin
            shift_q <= {shift_q[FRAME_W-2:0], 1'b0};
        end
    end

    assign sdo        = shift_q[FRAME_W-1];   // MSB first
    assign sclk       = sclk_q;
    assign cs_n       = cs_n_q;
    assign busy       = ~cs_n_q;
    assign frame_done = done_q;

endmodule

// ==== hdl/spi_tx_pkg.sv ====
// SPI transmit shared types

package spi_tx_pkg;

    // Bits per serial frame, shifted out MSB first
    localparam int FRAME_W = 8;

    // What the master does with chip select once a frame is out
    typedef enum logic {
        OP_WRITE      = 1'b0,   // Trail delay, then release cs_n
        OP_WRITE_CONT = 1'b1    // Keep cs_n low for the next frame
    } spi_op_e;

    // One queued frame request
    // Bit 8 holds the opcode, bits 7:0 the data byte
    typedef struct packed {
        spi_op_e            op;
        logic [FRAME_W-1:0] data;
    } spi_req_t;

endpackage

// ==== hdl/spi_tx_top.sv ====
// Write-only SPI master top
`timescale 1ns/1ps

module spi_tx_top import spi_tx_pkg::*; #(
    parameter int CLK_DIV    = 4,           // sclk period in system clocks
    parameter int FIFO_DEPTH = 4            // Request queue entries
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  spi_req_t req,
    output logic     req_ready,
    output logic     sdo,
    output logic     sclk,
    output logic     cs_n,
    output logic     busy,
    output logic     frame_done
);

    // Queue to shift engine
    logic     frm_valid;
    logic     frm_ready;
    spi_req_t frm;

    // Absorbs host bursts while the serial link drains
    spi_req_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_req    (req),
        .in_ready  (req_ready),
        .out_valid (frm_valid),
        .out_req   (frm),
        .out_ready (frm_ready)
    );

    spi_shift_master #(
        .CLK_DIV (CLK_DIV)
    ) u_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .frm_valid  (frm_valid),
        .frm        (frm),
        .frm_ready  (frm_ready),
        .sdo        (sdo),
        .sclk       (sclk),
        .cs_n       (cs_n),
        .busy       (busy),
        .frame_done (frame_done)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SPI transmit testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir
BIN=spi_tx_sim

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module spi_tx_tb -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qF "*** FAILED ***" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation log is clean"
exit 0

// ==== sim.f ====
hdl/spi_tx_pkg.sv
hdl/spi_req_fifo.sv
hdl/spi_shift_master.sv
hdl/spi_tx_top.sv
dv/spi_tx_sva.sv
dv/spi_tx_checker.sv
dv/spi_tx_tb.sv
